/* usb_ctl_pipe0.f */
logic/usb_ctl_pkg.sv
logic/ctl_req_decode.sv
logic/ctl_std_exec.sv
logic/desc_rom.sv
logic/desc_stream.sv
logic/usb_ctl_pipe0.sv
dv/usb_ctl_pipe0_assertions.sv
dv/usb_ctl_pipe0_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the endpoint-zero pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module usb_ctl_pipe0_tb \
  -f usb_ctl_pipe0.f -o usb_ctl_pipe0_sim > build.log 2>&1 &&
  ./obj_dir/usb_ctl_pipe0_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

/* dv/usb_ctl_pipe0_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_ctl_pipe0_tb
  import usb_ctl_pkg::*;
();

  logic        clock;
  logic        reset;
  logic        select;
  logic        start;
  logic [3:0]  req_endpt;
  logic [7:0]  req_type;
  logic [7:0]  req_request;
  logic [15:0] req_value;
  logic [15:0] req_index;
  logic [15:0] req_length;
  logic        m_tvalid;
  logic        m_tready;
  logic        m_tlast;
  logic [7:0]  m_tdata;
  logic        error;
  logic [6:0]  usb_addr;
  logic [2:0]  usb_conf;
  logic        usb_enum;
  logic        configured;

  logic [31:0] rng_state;
  logic [7:0]  expect_q[$];
  int          wait_limit = 100;
  int          checks = 0;
  int          errors = 0;

  usb_ctl_pipe0 UUT (
    .clock         (clock),
    .reset         (reset),
    .select_i      (select),
    .start_i       (start),
    .req_endpt_i   (req_endpt),
    .req_type_i    (req_type),
    .req_request_i (req_request),
    .req_value_i   (req_value),
    .req_index_i   (req_index),
    .req_length_i  (req_length),
    .m_tvalid_o    (m_tvalid),
    .m_tready_i    (m_tready),
    .m_tlast_o     (m_tlast),
    .m_tdata_o     (m_tdata),
    .error_o       (error),
    .usb_addr_o    (usb_addr),
    .usb_conf_o    (usb_conf),
    .usb_enum_o    (usb_enum),
    .configured_o  (configured)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // 32-bit LCG for the ready pattern
  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error: %s expected %0h, got %0h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Error: %s", what);
  endtask

  task automatic check_device_state(input logic [6:0] addr, input logic [2:0] conf,
                                    input logic enm, input logic cfg);
    check_value("usb_addr_o", 16'(usb_addr), 16'(addr));
    check_value("usb_conf_o", 16'(usb_conf), 16'(conf));
    check_value("usb_enum_o", 16'(usb_enum), 16'(enm));
    check_value("configured_o", 16'(configured), 16'(cfg));
  endtask

  // Reply bytes cut to wLength, the packet size and the descriptor end
  task automatic expect_reply(input desc_kind_e kind, input int wlength);
    int n;
    expect_q.delete();
    case (kind)
      desc_device:  n = desc_device_len;
      desc_config:  n = desc_config_len;
      desc_string0: n = desc_string0_len;
      default:      n = desc_status_len;
    endcase
    if (wlength < n) n = wlength;
    if (int'(max_packet_len) < n) n = int'(max_packet_len);
    for (int i = 0; i < n; i++) begin
      case (kind)
        desc_device:  expect_q.push_back(desc_device_bytes[i]);
        desc_config:  expect_q.push_back(desc_config_bytes[i]);
        desc_string0: expect_q.push_back(desc_string0_bytes[i]);
        // Self-powered bit in the device status only
        desc_status_device: expect_q.push_back((i == 0) ? 8'h01 : 8'h00);
        default: expect_q.push_back(8'h00);
      endcase
    end
  endtask

  task automatic send_request(input logic [7:0] rtype, input logic [7:0] request,
                              input logic [15:0] value, input logic [15:0] length);
    @(negedge clock);
    select      = 1'b1;
    start       = 1'b1;
    req_endpt   = 4'd0;
    req_type    = rtype;
    req_request = request;
    req_value   = value;
    req_index   = 16'd0;
    req_length  = length;
    @(negedge clock);
    start = 1'b0;
  endtask

  task automatic deselect();
    @(negedge clock);
    select   = 1'b0;
    m_tready = 1'b0;
    @(negedge clock);
  endtask

  // Stops on last, on a timeout, or after stop_after bytes when that is nonzero
  task automatic collect_reply(input bit random_ready, input int stop_after,
                               output int first_idle);
    int got;
    int idle;
    bit done;
    got = 0;
    idle = 0;
    done = 1'b0;
    first_idle = -1;
    while (!done && idle < wait_limit) begin
      @(negedge clock);
      if (random_ready) begin
        rng_state = next_random(rng_state);
        m_tready = rng_state[20];
      end else begin
        m_tready = 1'b1;
      end
      if (m_tvalid && first_idle < 0) first_idle = idle;
      if (m_tvalid && m_tready) begin
        if (got < expect_q.size()) begin
          check_value("m_tdata_o", 16'(m_tdata), 16'(expect_q[got]));
        end else begin
          report_failure("reply is longer than expected");
        end
        check_value("m_tlast_o", 16'(m_tlast), 16'(got == expect_q.size() - 1));
        got++;
        idle = 0;
        done = m_tlast || (got == stop_after);
      end else begin
        idle++;
      end
    end
    if (!done) report_failure("timed out waiting for a reply byte");
  endtask

  task automatic watch_no_stream(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      if (m_tvalid) report_failure("stream output for a request with no data stage");
    end
  endtask

  initial begin
    int first_idle;
    reset       = 1'b1;
    select      = 1'b0;
    start       = 1'b0;
    req_endpt   = 4'd0;
    req_type    = 8'h00;
    req_request = 8'h00;
    req_value   = 16'h0000;
    req_index   = 16'h0000;
    req_length  = 16'h0000;
    m_tready    = 1'b0;
    rng_state   = 32'h1509_b8f1;
    repeat (2) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    check_value("m_tvalid_o", 16'(m_tvalid), 16'd0);
    check_value("error_o", 16'(error), 16'd0);
    check_device_state(7'd0, 3'd0, 1'b0, 1'b0);

    // Device descriptor with ready held high and the first byte two cycles after start
    expect_reply(desc_device, 255);
    send_request(8'h80, req_get_descriptor, {desc_type_device, 8'h00}, 16'd255);
    check_value("m_tvalid_o", 16'(m_tvalid), 16'd0);
    collect_reply(1'b0, 0, first_idle);
    check_value("m_tvalid_o delay", 16'(first_idle), 16'd0);
    deselect();

    // Short configuration read and language list under back-pressure
    expect_reply(desc_config, 9);
    send_request(8'h80, req_get_descriptor, {desc_type_config, 8'h00}, 16'd9);
    collect_reply(1'b1, 0, first_idle);
    deselect();
    expect_reply(desc_string0, 64);
    send_request(8'h80, req_get_descriptor, {desc_type_string, 8'h00}, 16'd64);
    collect_reply(1'b1, 0, first_idle);
    deselect();

    send_request(8'h00, req_set_address, 16'h002a, 16'd0);
    watch_no_stream(1);
    check_device_state(7'h2a, 3'd0, 1'b1, 1'b0);
    watch_no_stream(3);
    deselect();
    send_request(8'h00, req_set_config, 16'h0001, 16'd0);
    watch_no_stream(1);
    check_device_state(7'h2a, 3'd1, 1'b1, 1'b1);
    watch_no_stream(3);
    deselect();

    expect_reply(desc_status_device, 2);
    send_request(8'h80, req_get_status, 16'h0000, 16'd2);
    collect_reply(1'b1, 0, first_idle);
    deselect();
    expect_reply(desc_status_iface, 2);
    send_request(8'h81, req_get_status, 16'h0000, 16'd2);
    collect_reply(1'b1, 0, first_idle);
    deselect();

    // Unsupported bRequest, then an absent descriptor type
    send_request(8'h00, 8'd3, 16'h0001, 16'd0);
    watch_no_stream(1);
    check_value("error_o", 16'(error), 16'd1);
    watch_no_stream(3);
    deselect();
    check_value("error_o", 16'(error), 16'd0);
    send_request(8'h80, req_get_descriptor, 16'h0600, 16'd10);
    watch_no_stream(1);
    check_value("error_o", 16'(error), 16'd1);
    watch_no_stream(3);
    deselect();
    check_value("error_o", 16'(error), 16'd0);

    // Abort mid-reply, then a full reply must follow cleanly
    expect_reply(desc_device, 255);
    send_request(8'h80, req_get_descriptor, {desc_type_device, 8'h00}, 16'd255);
    collect_reply(1'b1, 5, first_idle);
    deselect();
    check_value("m_tvalid_o", 16'(m_tvalid), 16'd0);
    expect_reply(desc_config, 255);
    send_request(8'h80, req_get_descriptor, {desc_type_config, 8'h00}, 16'd255);
    collect_reply(1'b1, 0, first_idle);
    deselect();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/usb_ctl_pipe0_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_ctl_pipe0_assertions
  import usb_ctl_pkg::*;
(
  input  wire logic       clock_i,
  input  wire logic       reset_i,
  input  wire logic       select_i,
  input  wire logic       strobe_i,
  input  ctl_op_e         op_i,
  input  wire logic       tvalid_i,
  input  wire logic       tready_i,
  input  wire logic       tlast_i,
  input  wire logic [7:0] tdata_i,
  input  wire logic       error_i,
  input  wire logic [6:0] addr_i,
  input  wire logic [2:0] conf_i,
  input  wire logic       enum_i,
  input  wire logic       configured_i
);

  // A stalled byte holds until it is taken or the pipe is deselected
  stall_hold: assert property (@(posedge clock_i) disable iff (reset_i)
    tvalid_i && !tready_i |=> !tvalid_i || ($stable(tdata_i) && $stable(tlast_i)))
    else $error("stream data or last changed while stalled");

  deselect_idle: assert property (@(posedge clock_i) disable iff (reset_i)
    !select_i |=> !tvalid_i)
    else $error("stream valid while deselected");

  // Strobe is one cycle after start, so the flag lands two cycles after start
  error_follows: assert property (@(posedge clock_i) disable iff (reset_i)
    strobe_i && op_i == op_unsupported && select_i |=> error_i)
    else $error("error flag missing after an unsupported request");

  reset_quiet: assert property (@(posedge clock_i)
    reset_i |=> !tvalid_i && !tlast_i && !error_i && !enum_i && !configured_i &&
                addr_i == 7'd0 && conf_i == 3'd0)
    else $error("outputs not quiet after reset");

endmodule

bind usb_ctl_pipe0 usb_ctl_pipe0_assertions u_assertions (
  .clock_i      (clock),
  .reset_i      (reset),
  .select_i     (select_i),
  .strobe_i     (req_strobe),
  .op_i         (req_op),
  .tvalid_i     (m_tvalid_o),
  .tready_i     (m_tready_i),
  .tlast_i      (m_tlast_o),
  .tdata_i      (m_tdata_o),
  .error_i      (error_o),
  .addr_i       (usb_addr_o),
  .conf_i       (usb_conf_o),
  .enum_i       (usb_enum_o),
  .configured_i (configured_o)
);

`default_nettype wire

/* logic/usb_ctl_pipe0.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_ctl_pipe0
  import usb_ctl_pkg::*;
(
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic        select_i,
  input  wire logic        start_i,
  input  wire logic [3:0]  req_endpt_i,
  input  wire logic [7:0]  req_type_i,
  input  wire logic [7:0]  req_request_i,
  input  wire logic [15:0] req_value_i,
  input  wire logic [15:0] req_index_i,
  input  wire logic [15:0] req_length_i,
  output logic             m_tvalid_o,
  input  wire logic        m_tready_i,
  output logic             m_tlast_o,
  output logic [7:0]       m_tdata_o,
  output logic             error_o,
  output logic [6:0]       usb_addr_o,
  output logic [2:0]       usb_conf_o,
  output logic             usb_enum_o,
  output logic             configured_o
);

  logic                     req_strobe;
  ctl_op_e                  req_op;
  desc_kind_e               req_kind;
  logic [15:0]              req_value;
  logic [6:0]               reply_len;
  logic                     stream_load;
  logic [rom_addr_bits-1:0] rom_start;
  logic [rom_addr_bits-1:0] rd_addr;
  logic [7:0]               rom_data;
  logic                     rom_last;

  // Only the two reading requests start a reply
  assign stream_load = req_strobe && (req_op == op_get_desc || req_op == op_get_status);

  ctl_req_decode u_decode (
    .clock_i       (clock),
    .reset_i       (reset),
    .select_i      (select_i),
    .start_i       (start_i),
    .req_endpt_i   (req_endpt_i),
    .req_type_i    (req_type_i),
    .req_request_i (req_request_i),
    .req_value_i   (req_value_i),
    .req_length_i  (req_length_i),
    .req_strobe_o  (req_strobe),
    .req_op_o      (req_op),
    .req_kind_o    (req_kind),
    .req_value_o   (req_value),
    .reply_len_o   (reply_len)
  );

  ctl_std_exec u_exec (
    .clock_i      (clock),
    .reset_i      (reset),
    .select_i     (select_i),
    .req_strobe_i (req_strobe),
    .req_op_i     (req_op),
    .req_value_i  (req_value),
    .error_o      (error_o),
    .usb_addr_o   (usb_addr_o),
    .usb_conf_o   (usb_conf_o),
    .usb_enum_o   (usb_enum_o),
    .configured_o (configured_o)
  );

  desc_rom u_rom (
    .clock_i      (clock),
    .kind_i       (req_kind),
    .rd_addr_i    (rd_addr),
    .start_addr_o (rom_start),
    .rd_data_o    (rom_data),
    .rd_last_o    (rom_last)
  );

  desc_stream u_stream (
    .clock_i     (clock),
    .reset_i     (reset),
    .select_i    (select_i),
    .load_i      (stream_load),
    .rom_start_i (rom_start),
    .reply_len_i (reply_len),
    .rom_data_i  (rom_data),
    .rom_last_i  (rom_last),
    .m_tready_i  (m_tready_i),
    .rd_addr_o   (rd_addr),
    .m_tvalid_o  (m_tvalid_o),
    .m_tlast_o   (m_tlast_o),
    .m_tdata_o   (m_tdata_o)
  );

endmodule

`default_nettype wire

/* logic/desc_stream.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_stream
  import usb_ctl_pkg::*;
(
  input  wire logic                     clock_i,
  input  wire logic                     reset_i,
  input  wire logic                     select_i,
  input  wire logic                     load_i,
  input  wire logic [rom_addr_bits-1:0] rom_start_i,
  input  wire logic [6:0]               reply_len_i,
  input  wire logic [7:0]               rom_data_i,
  input  wire logic                     rom_last_i,
  input  wire logic                     m_tready_i,
  output logic [rom_addr_bits-1:0]      rd_addr_o,
  output logic                          m_tvalid_o,
  output logic                          m_tlast_o,
  output logic [7:0]                    m_tdata_o
);

  logic [rom_addr_bits-1:0] addr_q;
  logic [6:0]               left_q;
  logic                     valid_q;
  logic                     xfer;
  logic                     final_byte;

  assign xfer = valid_q && m_tready_i;

  // Budget of one left or the end of the descriptor, whichever comes first
  assign final_byte = rom_last_i || (left_q == 7'd1);

  // Look-ahead read fetches the next byte as the current one is taken
  // and re-reads the same address so the output holds under a stall
  always_comb begin
    if (load_i) begin
      rd_addr_o = rom_start_i;
    end else if (xfer) begin
      rd_addr_o = addr_q + 1'b1;
    end else begin
      rd_addr_o = addr_q;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      addr_q <= '0;
      left_q <= 7'd0;
    end else begin
      addr_q <= rd_addr_o;
      if (load_i) begin
        left_q <= reply_len_i;
      end else if (xfer) begin
        left_q <= left_q - 7'd1;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i || !select_i) begin
      valid_q <= 1'b0;
    end else if (load_i) begin
      // A zero wLength asks for no data at all
      valid_q <= (reply_len_i != 7'd0);
    end else if (xfer && final_byte) begin
      valid_q <= 1'b0;
    end
  end

  assign m_tvalid_o = valid_q;
  assign m_tlast_o  = valid_q && final_byte;
  assign m_tdata_o  = rom_data_i;

endmodule

`default_nettype wire

/* logic/desc_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_rom
  import usb_ctl_pkg::*;
(
  input  wire logic                     clock_i,
  input  desc_kind_e                    kind_i,
  input  wire logic [rom_addr_bits-1:0] rd_addr_i,
  output logic [rom_addr_bits-1:0]      start_addr_o,
  output logic [7:0]                    rd_data_o,
  output logic                          rd_last_o
);

  logic [7:0] rom_data [desc_rom_size];
  logic       rom_end  [desc_rom_size];

  // Device, configuration and language list followed by three status words
  function automatic logic [7:0] rom_byte(input int a);
    logic [7:0] b;
    b = 8'h00;
    if (a < int'(config_start)) begin
      b = desc_device_bytes[a];
    end else if (a < int'(string0_start)) begin
      b = desc_config_bytes[a - int'(config_start)];
    end else if (a < int'(status_start)) begin
      b = desc_string0_bytes[a - int'(string0_start)];
    end else if (a == int'(status_start)) begin
      // Device status reports self-powered
      b = 8'h01;
    end
    return b;
  endfunction

  function automatic logic rom_last(input int a);
    return (a == int'(config_start) - 1) ||
           (a == int'(string0_start) - 1) ||
           (a == int'(status_start) - 1) ||
           (a == int'(status_start) + desc_status_len - 1) ||
           (a == int'(status_start) + 2 * desc_status_len - 1) ||
           (a == int'(status_start) + 3 * desc_status_len - 1);
  endfunction

  for (genvar a = 0; a < desc_rom_size; a++) begin : g_rom
    assign rom_data[a] = rom_byte(a);
    assign rom_end[a]  = rom_last(a);
  end

  always_comb begin
    case (kind_i)
      desc_device:        start_addr_o = device_start;
      desc_config:        start_addr_o = config_start;
      desc_string0:       start_addr_o = string0_start;
      desc_status_device: start_addr_o = status_start;
      desc_status_iface:  start_addr_o = rom_addr_bits'(status_start + desc_status_len);
      desc_status_endpt:  start_addr_o = rom_addr_bits'(status_start + 2 * desc_status_len);
      default:            start_addr_o = device_start;
    endcase
  end

  always_ff @(posedge clock_i) begin
    rd_data_o <= rom_data[rd_addr_i];
    rd_last_o <= rom_end[rd_addr_i];
  end

endmodule

`default_nettype wire

/* logic/ctl_std_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module ctl_std_exec
  import usb_ctl_pkg::*;
(
  input  wire logic        clock_i,
  input  wire logic        reset_i,
  input  wire logic        select_i,
  input  wire logic        req_strobe_i,
  input  ctl_op_e          req_op_i,
  input  wire logic [15:0] req_value_i,
  output logic             error_o,
  output logic [6:0]       usb_addr_o,
  output logic [2:0]       usb_conf_o,
  output logic             usb_enum_o,
  output logic             configured_o
);

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      usb_addr_o   <= 7'd0;
      usb_conf_o   <= 3'd0;
      usb_enum_o   <= 1'b0;
      configured_o <= 1'b0;
    end else if (req_strobe_i) begin
      case (req_op_i)
        op_set_address: begin
          usb_addr_o <= req_value_i[6:0];
          usb_enum_o <= 1'b1;
        end
        // Configuration value zero returns the device to the addressed state
        op_set_config: begin
          usb_conf_o   <= req_value_i[2:0];
          configured_o <= (req_value_i[7:0] != 8'd0);
        end
        // Only alternate setting zero exists so there is nothing to record
        op_set_iface: ;
        default: ;
      endcase
    end
  end

  // Error holds for the rest of the control transfer
  always_ff @(posedge clock_i) begin
    if (reset_i || !select_i) begin
      error_o <= 1'b0;
    end else if (req_strobe_i && req_op_i == op_unsupported) begin
      error_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/ctl_req_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ctl_req_decode
  import usb_ctl_pkg::*;
(
  input  wire logic        clock_i,
  input  wire logic        reset_i,
  input  wire logic        select_i,
  input  wire logic        start_i,
  input  wire logic [3:0]  req_endpt_i,
  input  wire logic [7:0]  req_type_i,
  input  wire logic [7:0]  req_request_i,
  input  wire logic [15:0] req_value_i,
  input  wire logic [15:0] req_length_i,
  output logic             req_strobe_o,
  output ctl_op_e          req_op_o,
  output desc_kind_e       req_kind_o,
  output logic [15:0]      req_value_o,
  output logic [6:0]       reply_len_o
);

  logic       accept;
  logic       std_type;
  logic [4:0] recipient;
  logic [6:0] len_cap;
  ctl_op_e    op_next;
  desc_kind_e kind_next;

  assign accept    = select_i && start_i && (req_endpt_i == 4'd0);
  assign std_type  = (req_type_i[6:5] == 2'b00);
  assign recipient = req_type_i[4:0];
  assign len_cap   = (req_length_i > 16'(max_packet_len)) ? max_packet_len : req_length_i[6:0];

  always_comb begin
    op_next   = op_none;
    kind_next = desc_device;
    if (std_type && req_request_i == req_get_status) begin
      // Recipient picks which status word is returned
      case (recipient)
        5'd0: begin
          op_next   = op_get_status;
          kind_next = desc_status_device;
        end
        5'd1: begin
          op_next   = op_get_status;
          kind_next = desc_status_iface;
        end
        5'd2: begin
          op_next   = op_get_status;
          kind_next = desc_status_endpt;
        end
        default: op_next = op_unsupported;
      endcase
    end else if (std_type && recipient == 5'd0) begin
      case (req_request_i)
        req_set_address: op_next = op_set_address;
        req_set_config:  op_next = op_set_config;
        req_set_iface:   op_next = op_set_iface;
        req_get_descriptor: begin
          op_next = op_get_desc;
          case (req_value_i[15:8])
            desc_type_device: kind_next = desc_device;
            desc_type_config: kind_next = desc_config;
            // Only the language list exists among the strings
            desc_type_string: begin
              kind_next = desc_string0;
              if (req_value_i[7:0] != 8'd0) begin
                op_next = op_unsupported;
              end
            end
            default: op_next = op_unsupported;
          endcase
        end
        default: op_next = op_unsupported;
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      req_strobe_o <= 1'b0;
      req_op_o     <= op_none;
    end else begin
      req_strobe_o <= accept;
      if (accept) begin
        req_op_o <= op_next;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (accept) begin
      req_kind_o  <= kind_next;
      req_value_o <= req_value_i;
      reply_len_o <= len_cap;
    end
  end

endmodule

`default_nettype wire

/* logic/usb_ctl_pkg.sv */
`default_nettype none

package usb_ctl_pkg;

  // Decoded standard request
  typedef enum logic [2:0] {
    op_none,
    op_set_address,
    op_set_config,
    op_set_iface,
    op_get_desc,
    op_get_status,
    op_unsupported
  } ctl_op_e;

  // Reply chosen for the descriptor streamer
  typedef enum logic [2:0] {
    desc_device,
    desc_config,
    desc_string0,
    desc_status_device,
    desc_status_iface,
    desc_status_endpt
  } desc_kind_e;

  // bRequest codes
  localparam logic [7:0] req_get_status     = 8'd0;
  localparam logic [7:0] req_set_address    = 8'd5;
  localparam logic [7:0] req_get_descriptor = 8'd6;
  localparam logic [7:0] req_set_config     = 8'd9;
  localparam logic [7:0] req_set_iface      = 8'd11;

  // Descriptor types, high byte of wValue
  localparam logic [7:0] desc_type_device = 8'd1;
  localparam logic [7:0] desc_type_config = 8'd2;
  localparam logic [7:0] desc_type_string = 8'd3;

  localparam logic [15:0] vendor_id  = 16'hface;
  localparam logic [15:0] product_id = 16'h0bde;

  localparam int desc_device_len  = 18;
  localparam int desc_config_len  = 18;
  localparam int desc_string0_len = 4;
  localparam int desc_status_len  = 2;

  localparam int desc_rom_size = 64;
  localparam int rom_addr_bits = 6;

  localparam logic [6:0] max_packet_len = 7'd64;

  // USB 2.0, vendor class, max packet 64, one configuration
  localparam logic [0:desc_device_len-1][7:0] desc_device_bytes = {
    8'h12, 8'h01, 8'h00, 8'h02, 8'hff, 8'h00, 8'h00, 8'h40,
    vendor_id[7:0], vendor_id[15:8], product_id[7:0], product_id[15:8],
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01
  };

  // Self-powered 100 mA configuration with one interface and no endpoints
  localparam logic [0:desc_config_len-1][7:0] desc_config_bytes = {
    8'h09, 8'h02, 8'h12, 8'h00, 8'h01, 8'h01, 8'h00, 8'hc0, 8'h32,
    8'h09, 8'h04, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00
  };

  // Language list, US English only
  localparam logic [0:desc_string0_len-1][7:0] desc_string0_bytes = {
    8'h04, 8'h03, 8'h09, 8'h04
  };

  localparam logic [rom_addr_bits-1:0] device_start  = '0;
  localparam logic [rom_addr_bits-1:0] config_start  =
    rom_addr_bits'(device_start + desc_device_len);
  localparam logic [rom_addr_bits-1:0] string0_start =
    rom_addr_bits'(config_start + desc_config_len);
  localparam logic [rom_addr_bits-1:0] status_start  =
    rom_addr_bits'(string0_start + desc_string0_len);

endpackage

`default_nettype wire
